//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := cluster_fabric_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
hw/fabric_pkg.sv
hw/io_req_arb.sv
hw/io_rsp_router.sv
hw/csr_router.sv
hw/cluster_fabric.sv
sim/tb_clock_gen.sv
sim/cluster_fabric_tb.sv

//--- hw/cluster_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module cluster_fabric (
    input  logic                                                    clk,
    input  logic                                                    reset,

    // Cluster I/O requests
    input  logic [fabric_pkg::NUM_CLUSTERS-1:0]                     cl_io_req_valid,
    input  fabric_pkg::io_req_t [fabric_pkg::NUM_CLUSTERS-1:0]      cl_io_req,
    output logic [fabric_pkg::NUM_CLUSTERS-1:0]                     cl_io_req_ready,

    // Cluster I/O responses
    output logic [fabric_pkg::NUM_CLUSTERS-1:0]                     cl_io_rsp_valid,
    output fabric_pkg::io_rsp_t [fabric_pkg::NUM_CLUSTERS-1:0]      cl_io_rsp,
    input  logic [fabric_pkg::NUM_CLUSTERS-1:0]                     cl_io_rsp_ready,

    // External I/O
    output logic                                                    io_req_valid,
    output fabric_pkg::io_ext_req_t                                 io_req,
    input  logic                                                    io_req_ready,
    input  logic                                                    io_rsp_valid,
    input  fabric_pkg::io_ext_rsp_t                                 io_rsp,
    output logic                                                    io_rsp_ready,

    // Cluster CSR side
    output logic [fabric_pkg::NUM_CLUSTERS-1:0]                     cl_csr_req_valid,
    output fabric_pkg::csr_cluster_req_t                            cl_csr_req,
    input  logic [fabric_pkg::NUM_CLUSTERS-1:0]                     cl_csr_req_ready,
    input  logic [fabric_pkg::NUM_CLUSTERS-1:0]                     cl_csr_rsp_valid,
    input  logic [fabric_pkg::NUM_CLUSTERS-1:0][fabric_pkg::DATA_WIDTH-1:0] cl_csr_rsp_data,
    output logic [fabric_pkg::NUM_CLUSTERS-1:0]                     cl_csr_rsp_ready,

    // External CSR
    input  logic                                                    csr_req_valid,
    input  fabric_pkg::csr_req_t                                    csr_req,
    output logic                                                    csr_req_ready,
    output logic                                                    csr_rsp_valid,
    output logic [fabric_pkg::DATA_WIDTH-1:0]                       csr_rsp_data,
    input  logic                                                    csr_rsp_ready
);

    io_req_arb io_req_arb_i (
        .clk             (clk),
        .reset           (reset),
        .cl_io_req_valid (cl_io_req_valid),
        .cl_io_req       (cl_io_req),
        .cl_io_req_ready (cl_io_req_ready),
        .io_req_valid    (io_req_valid),
        .io_req          (io_req),
        .io_req_ready    (io_req_ready)
    );

    io_rsp_router io_rsp_router_i (
        .clk             (clk),
        .io_rsp_valid    (io_rsp_valid),
        .io_rsp          (io_rsp),
        .io_rsp_ready    (io_rsp_ready),
        .cl_io_rsp_valid (cl_io_rsp_valid),
        .cl_io_rsp       (cl_io_rsp),
        .cl_io_rsp_ready (cl_io_rsp_ready)
    );

    csr_router csr_router_i (
        .clk              (clk),
        .reset            (reset),
        .csr_req_valid    (csr_req_valid),
        .csr_req          (csr_req),
        .csr_req_ready    (csr_req_ready),
        .cl_csr_req_valid (cl_csr_req_valid),
        .cl_csr_req       (cl_csr_req),
        .cl_csr_req_ready (cl_csr_req_ready),
        .cl_csr_rsp_valid (cl_csr_rsp_valid),
        .cl_csr_rsp_data  (cl_csr_rsp_data),
        .cl_csr_rsp_ready (cl_csr_rsp_ready),
        .csr_rsp_valid    (csr_rsp_valid),
        .csr_rsp_data     (csr_rsp_data),
        .csr_rsp_ready    (csr_rsp_ready)
    );

endmodule

`default_nettype wire

//--- hw/csr_router.sv
`timescale 1ns/1ps
`default_nettype none

module csr_router (
    input  logic                                                    clk,
    input  logic                                                    reset,

    input  logic                                                    csr_req_valid,
    input  fabric_pkg::csr_req_t                                    csr_req,
    output logic                                                    csr_req_ready,

    output logic [fabric_pkg::NUM_CLUSTERS-1:0]                     cl_csr_req_valid,
    output fabric_pkg::csr_cluster_req_t                            cl_csr_req,
    input  logic [fabric_pkg::NUM_CLUSTERS-1:0]                     cl_csr_req_ready,

    input  logic [fabric_pkg::NUM_CLUSTERS-1:0]                     cl_csr_rsp_valid,
    input  logic [fabric_pkg::NUM_CLUSTERS-1:0][fabric_pkg::DATA_WIDTH-1:0] cl_csr_rsp_data,
    output logic [fabric_pkg::NUM_CLUSTERS-1:0]                     cl_csr_rsp_ready,

    output logic                                                    csr_rsp_valid,
    output logic [fabric_pkg::DATA_WIDTH-1:0]                       csr_rsp_data,
    input  logic                                                    csr_rsp_ready
);

    fabric_pkg::csr_state_e              state;
    fabric_pkg::csr_state_e              state_next;
    logic [fabric_pkg::CLUSTER_BITS-1:0] target;
    logic                                req_fire;

    assign req_fire = csr_req_valid && csr_req_ready;

    always_comb begin
        state_next = state;
        case (state)
            fabric_pkg::CSR_IDLE: if (req_fire) state_next = fabric_pkg::CSR_SEND;
            fabric_pkg::CSR_SEND: if (cl_csr_req_ready[target]) state_next = fabric_pkg::CSR_WAIT;
            fabric_pkg::CSR_WAIT: if (cl_csr_rsp_valid[target]) state_next = fabric_pkg::CSR_RESP;
            fabric_pkg::CSR_RESP: if (csr_rsp_ready) state_next = fabric_pkg::CSR_IDLE;
            default:              state_next = fabric_pkg::CSR_IDLE;
        endcase
    end

    // Only the owning cluster sees valid or ready
    always_comb begin
        cl_csr_req_valid = '0;
        cl_csr_rsp_ready = '0;
        cl_csr_req_valid[target] = (state == fabric_pkg::CSR_SEND);
        cl_csr_rsp_ready[target] = (state == fabric_pkg::CSR_WAIT);
    end

    assign csr_rsp_valid = (state == fabric_pkg::CSR_RESP);

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= fabric_pkg::CSR_IDLE;
            csr_req_ready <= 1'b0;
            target        <= '0;
        end else begin
            state         <= state_next;
            csr_req_ready <= (state_next == fabric_pkg::CSR_IDLE);
            if (req_fire) begin
                target <= fabric_pkg::CLUSTER_BITS'(csr_req.coreid >> fabric_pkg::CORE_BITS);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            cl_csr_req.core <= csr_req.coreid[fabric_pkg::CORE_BITS-1:0];
            cl_csr_req.addr <= csr_req.addr;
            cl_csr_req.rw   <= csr_req.rw;
            cl_csr_req.data <= csr_req.data;
        end
        if (state == fabric_pkg::CSR_WAIT && cl_csr_rsp_valid[target]) begin
            csr_rsp_data <= cl_csr_rsp_data[target];
        end
    end

    // No new request while a response is pending
    assert property (@(posedge clk) disable iff (reset)
        csr_rsp_valid |-> state == fabric_pkg::CSR_RESP && !csr_req_ready);

    assert property (@(posedge clk) disable iff (reset)
        csr_rsp_valid && !csr_rsp_ready |=> csr_rsp_valid && $stable(csr_rsp_data));

endmodule

`default_nettype wire

//--- hw/fabric_pkg.sv
`default_nettype none

package fabric_pkg;

    localparam int NUM_CLUSTERS   = 4;
    localparam int CLUSTER_BITS   = 2;
    localparam int CORE_BITS      = 2;
    localparam int CSR_ID_WIDTH   = CLUSTER_BITS + CORE_BITS;
    localparam int ADDR_WIDTH     = 30;
    localparam int DATA_WIDTH     = 32;
    localparam int BYTEEN_WIDTH   = 4;
    localparam int CORE_TAG_WIDTH = 4;
    localparam int IO_TAG_WIDTH   = CLUSTER_BITS + CORE_TAG_WIDTH;
    localparam int CSR_ADDR_WIDTH = 12;

    typedef enum logic {
        IO_READ  = 1'b0,
        IO_WRITE = 1'b1
    } io_op_e;

    typedef enum logic [1:0] {
        CSR_IDLE = 2'd0,
        CSR_SEND = 2'd1,
        CSR_WAIT = 2'd2,
        CSR_RESP = 2'd3
    } csr_state_e;

    // Cluster side I/O request
    typedef struct packed {
        io_op_e                    op;
        logic [BYTEEN_WIDTH-1:0]   byteen;
        logic [ADDR_WIDTH-1:0]     addr;
        logic [DATA_WIDTH-1:0]     data;
        logic [CORE_TAG_WIDTH-1:0] tag;
    } io_req_t;

    // External I/O request, cluster index on top of the tag
    typedef struct packed {
        io_op_e                    op;
        logic [BYTEEN_WIDTH-1:0]   byteen;
        logic [ADDR_WIDTH-1:0]     addr;
        logic [DATA_WIDTH-1:0]     data;
        logic [IO_TAG_WIDTH-1:0]   tag;
    } io_ext_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]     data;
        logic [CORE_TAG_WIDTH-1:0] tag;
    } io_rsp_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]     data;
        logic [IO_TAG_WIDTH-1:0]   tag;
    } io_ext_rsp_t;

    typedef struct packed {
        logic [CSR_ID_WIDTH-1:0]   coreid;
        logic [CSR_ADDR_WIDTH-1:0] addr;
        logic                      rw;
        logic [DATA_WIDTH-1:0]     data;
    } csr_req_t;

    typedef struct packed {
        logic [CORE_BITS-1:0]      core;
        logic [CSR_ADDR_WIDTH-1:0] addr;
        logic                      rw;
        logic [DATA_WIDTH-1:0]     data;
    } csr_cluster_req_t;

endpackage

`default_nettype wire

//--- hw/io_req_arb.sv
`timescale 1ns/1ps
`default_nettype none

module io_req_arb (
    input  logic                                                   clk,
    input  logic                                                   reset,

    input  logic [fabric_pkg::NUM_CLUSTERS-1:0]                    cl_io_req_valid,
    input  fabric_pkg::io_req_t [fabric_pkg::NUM_CLUSTERS-1:0]     cl_io_req,
    output logic [fabric_pkg::NUM_CLUSTERS-1:0]                    cl_io_req_ready,

    output logic                                                   io_req_valid,
    output fabric_pkg::io_ext_req_t                                io_req,
    input  logic                                                   io_req_ready
);

    logic [fabric_pkg::CLUSTER_BITS-1:0] last_grant;
    logic [fabric_pkg::CLUSTER_BITS-1:0] grant_idx;
    logic                                grant_found;
    logic                                accept;
    fabric_pkg::io_req_t                 grant_req;

    // First valid cluster after the last granted one
    always_comb begin
        logic [fabric_pkg::CLUSTER_BITS-1:0] cand;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int i = 1; i <= fabric_pkg::NUM_CLUSTERS; i++) begin
            cand = last_grant + fabric_pkg::CLUSTER_BITS'(i);
            if (!grant_found && cl_io_req_valid[cand]) begin
                grant_found = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    assign grant_req = cl_io_req[grant_idx];

    // Output register is free whenever the target takes its content
    assign accept = grant_found && io_req_ready;

    always_comb begin
        cl_io_req_ready = '0;
        cl_io_req_ready[grant_idx] = accept;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            io_req_valid <= 1'b0;
            // Cluster 0 goes first after reset
            last_grant   <= '1;
        end else begin
            if (accept) begin
                io_req_valid <= 1'b1;
                last_grant   <= grant_idx;
            end else if (io_req_ready) begin
                io_req_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            io_req.op     <= grant_req.op;
            io_req.byteen <= grant_req.byteen;
            io_req.addr   <= grant_req.addr;
            io_req.data   <= grant_req.data;
            io_req.tag    <= {grant_idx, grant_req.tag};
        end
    end

    // Stalled request must not change
    assert property (@(posedge clk) disable iff (reset)
        io_req_valid && !io_req_ready |=> io_req_valid && $stable(io_req));

endmodule

`default_nettype wire

//--- hw/io_rsp_router.sv
`timescale 1ns/1ps
`default_nettype none

module io_rsp_router (
    input  logic                                               clk,

    input  logic                                               io_rsp_valid,
    input  fabric_pkg::io_ext_rsp_t                            io_rsp,
    output logic                                               io_rsp_ready,

    output logic [fabric_pkg::NUM_CLUSTERS-1:0]                cl_io_rsp_valid,
    output fabric_pkg::io_rsp_t [fabric_pkg::NUM_CLUSTERS-1:0] cl_io_rsp,
    input  logic [fabric_pkg::NUM_CLUSTERS-1:0]                cl_io_rsp_ready
);

    logic [fabric_pkg::CLUSTER_BITS-1:0] rsp_cluster;

    // Upper tag bits name the cluster
    assign rsp_cluster = io_rsp.tag[fabric_pkg::IO_TAG_WIDTH-1 -: fabric_pkg::CLUSTER_BITS];

    for (genvar i = 0; i < fabric_pkg::NUM_CLUSTERS; i++) begin : g_cluster
        assign cl_io_rsp_valid[i] = io_rsp_valid
                                 && (rsp_cluster == fabric_pkg::CLUSTER_BITS'(i));
        assign cl_io_rsp[i].data  = io_rsp.data;
        assign cl_io_rsp[i].tag   = io_rsp.tag[fabric_pkg::CORE_TAG_WIDTH-1:0];
    end

    assign io_rsp_ready = cl_io_rsp_ready[rsp_cluster];

    assert property (@(posedge clk)
        $onehot0(cl_io_rsp_valid) && (io_rsp_valid == (|cl_io_rsp_valid)));

endmodule

`default_nettype wire

//--- sim/cluster_fabric_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cluster_fabric_tb;

    localparam int NCL            = fabric_pkg::NUM_CLUSTERS;
    localparam int IO_PER_CLUSTER = 50;
    localparam int IO_TOTAL       = IO_PER_CLUSTER * NCL;
    localparam int CSR_TOTAL      = 20;
    localparam int WATCHDOG_CYCLES = (IO_TOTAL + CSR_TOTAL) * 400;

    logic clk;
    logic reset;

    logic [NCL-1:0]                            cl_io_req_valid;
    fabric_pkg::io_req_t [NCL-1:0]             cl_io_req;
    logic [NCL-1:0]                            cl_io_req_ready;
    logic [NCL-1:0]                            cl_io_rsp_valid;
    fabric_pkg::io_rsp_t [NCL-1:0]             cl_io_rsp;
    logic [NCL-1:0]                            cl_io_rsp_ready;
    logic                                      io_req_valid;
    fabric_pkg::io_ext_req_t                   io_req;
    logic                                      io_req_ready;
    logic                                      io_rsp_valid;
    fabric_pkg::io_ext_rsp_t                   io_rsp;
    logic                                      io_rsp_ready;
    logic [NCL-1:0]                            cl_csr_req_valid;
    fabric_pkg::csr_cluster_req_t              cl_csr_req;
    logic [NCL-1:0]                            cl_csr_req_ready;
    logic [NCL-1:0]                            cl_csr_rsp_valid;
    logic [NCL-1:0][fabric_pkg::DATA_WIDTH-1:0] cl_csr_rsp_data;
    logic [NCL-1:0]                            cl_csr_rsp_ready;
    logic                                      csr_req_valid;
    fabric_pkg::csr_req_t                      csr_req;
    logic                                      csr_req_ready;
    logic                                      csr_rsp_valid;
    logic [fabric_pkg::DATA_WIDTH-1:0]         csr_rsp_data;
    logic                                      csr_rsp_ready;

    int seed = 35;
    int error_count = 0;
    int io_done = 0;
    int csr_done = 0;

    fabric_pkg::io_ext_req_t      exp_q [NCL][$];
    fabric_pkg::io_ext_req_t      pend_q [$];
    logic [1:0]                   exp_csr_target;
    fabric_pkg::csr_cluster_req_t exp_csr_cluster_req;

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    cluster_fabric cluster_fabric_i (.*);

    function automatic fabric_pkg::io_ext_req_t expect_io_req(input logic [1:0] c,
                                                              input fabric_pkg::io_req_t r);
        fabric_pkg::io_ext_req_t e;
        e.op     = r.op;
        e.byteen = r.byteen;
        e.addr   = r.addr;
        e.data   = r.data;
        e.tag    = {c, r.tag};
        return e;
    endfunction

    function automatic logic [1:0] expect_csr_target(input logic [3:0] coreid);
        return coreid[3:2];
    endfunction

    function automatic logic [31:0] expect_csr_data(input logic [11:0] addr, input logic [1:0] c);
        return {20'd0, addr} ^ {30'd0, c};
    endfunction

    // One-hot grant, first valid cluster after the last one
    function automatic logic [3:0] expect_grant(input logic [1:0] last, input logic [3:0] valid);
        logic [1:0] cand;
        logic [3:0] g;
        g = '0;
        for (int i = 1; i <= NCL; i++) begin
            cand = last + 2'(i);
            if (g == '0 && valid[cand]) g[cand] = 1'b1;
        end
        return g;
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    // Cluster I/O request drivers
    initial begin
        int         r;
        int         issued [NCL];
        logic [3:0] taken;
        logic       in_reset;
        cl_io_req_valid = '0;
        cl_io_req       = '0;
        issued          = '{default: 0};
        forever begin
            @(posedge clk);
            taken    = cl_io_req_valid & cl_io_req_ready;
            in_reset = reset;
            @(negedge clk);
            if (!in_reset) begin
                for (int c = 0; c < NCL; c++) begin
                    if (taken[c]) cl_io_req_valid[c] = 1'b0;
                    r = $random(seed);
                    if (!cl_io_req_valid[c] && issued[c] < IO_PER_CLUSTER && r[1:0] != 2'b00) begin
                        cl_io_req[c].op     = fabric_pkg::io_op_e'(r[2]);
                        cl_io_req[c].byteen = r[6:3];
                        cl_io_req[c].addr   = 30'($random(seed));
                        cl_io_req[c].data   = $random(seed);
                        cl_io_req[c].tag    = 4'(issued[c]);
                        cl_io_req_valid[c]  = 1'b1;
                        issued[c]++;
                    end
                end
            end
        end
    end

    // External target, answers out of order with addr plus tag
    initial begin
        int   r;
        int   idx;
        logic rsp_taken;
        logic in_reset;
        io_req_ready    = 1'b0;
        io_rsp_valid    = 1'b0;
        io_rsp          = '0;
        cl_io_rsp_ready = '0;
        forever begin
            @(posedge clk);
            in_reset = reset;
            if (!in_reset && io_req_valid && io_req_ready) pend_q.push_back(io_req);
            rsp_taken = io_rsp_valid && io_rsp_ready;
            @(negedge clk);
            if (rsp_taken) begin
                io_rsp_valid = 1'b0;
                io_done++;
            end
            r = $random(seed);
            io_req_ready    = !in_reset && (r[1:0] != 2'b00);
            cl_io_rsp_ready = r[5:2];
            if (!io_rsp_valid && pend_q.size() > 0 && r[6]) begin
                r   = $random(seed);
                idx = (r & 32'h7fff_ffff) % pend_q.size();
                io_rsp.data  = 32'(pend_q[idx].addr) + 32'(pend_q[idx].tag);
                io_rsp.tag   = pend_q[idx].tag;
                io_rsp_valid = 1'b1;
                pend_q.delete(idx);
            end
        end
    end

    // Cluster CSR models
    initial begin
        int          r;
        logic [1:0]  c;
        logic [11:0] addr;
        logic        hit;
        cl_csr_req_ready = '0;
        cl_csr_rsp_valid = '0;
        cl_csr_rsp_data  = '0;
        forever begin
            @(negedge clk);
            r = $random(seed);
            cl_csr_req_ready = r[3:0];
            @(posedge clk);
            hit = 1'b0;
            for (int i = 0; i < NCL; i++) begin
                if (cl_csr_req_valid[i] && cl_csr_req_ready[i]) begin
                    c   = 2'(i);
                    hit = 1'b1;
                end
            end
            if (hit) begin
                addr = cl_csr_req.addr;
                @(negedge clk);
                cl_csr_req_ready = '0;
                r = $random(seed);
                repeat (r[2:0]) @(negedge clk);
                cl_csr_rsp_valid[c] = 1'b1;
                cl_csr_rsp_data[c]  = 32'(addr) ^ 32'(c);
                @(posedge clk);
                while (!cl_csr_rsp_ready[c]) @(posedge clk);
                @(negedge clk);
                cl_csr_rsp_valid[c] = 1'b0;
            end
        end
    end

    // External CSR requests, one at a time
    initial begin
        fabric_pkg::csr_req_t req;
        int                   r;
        logic                 got;
        csr_req_valid = 1'b0;
        csr_req       = '0;
        csr_rsp_ready = 1'b0;
        wait (!reset);
        @(negedge clk);
        for (int n = 0; n < CSR_TOTAL; n++) begin
            r = $random(seed);
            repeat (r[18:17]) @(negedge clk);
            req.coreid = r[3:0];
            req.addr   = r[15:4];
            req.rw     = r[16];
            req.data   = $random(seed);
            exp_csr_target           = expect_csr_target(req.coreid);
            exp_csr_cluster_req.core = req.coreid[1:0];
            exp_csr_cluster_req.addr = req.addr;
            exp_csr_cluster_req.rw   = req.rw;
            exp_csr_cluster_req.data = req.data;
            csr_req       = req;
            csr_req_valid = 1'b1;
            @(posedge clk);
            while (!csr_req_ready) @(posedge clk);
            @(negedge clk);
            csr_req_valid = 1'b0;
            got = 1'b0;
            while (!got) begin
                r = $random(seed);
                csr_rsp_ready = r[0];
                @(posedge clk);
                check_value("csr_req_ready", 128'(csr_req_ready), 128'(0));
                if (csr_rsp_valid && csr_rsp_ready) begin
                    check_value("csr_rsp_data", 128'(csr_rsp_data),
                                128'(expect_csr_data(req.addr, exp_csr_target)));
                    got = 1'b1;
                end
                @(negedge clk);
            end
            csr_rsp_ready = 1'b0;
            csr_done++;
        end
    end

    // Compare process
    logic [1:0]              rr_last = 2'd3;
    logic                    hold_valid = 1'b0;
    fabric_pkg::io_ext_req_t held_req;
    logic                    prev_reset = 1'b1;
    int                      cycle_cnt = 0;

    always @(posedge clk) begin
        logic [1:0]              c;
        fabric_pkg::io_ext_req_t exp_req;
        cycle_cnt++;
        if (cycle_cnt > 1 && (reset || prev_reset)) begin
            check_value("io_req_valid", 128'(io_req_valid), 128'(0));
            check_value("csr_rsp_valid", 128'(csr_rsp_valid), 128'(0));
            check_value("cl_csr_req_valid", 128'(cl_csr_req_valid), 128'(0));
            check_value("csr_req_ready", 128'(csr_req_ready), 128'(0));
        end
        if (!reset) begin
            check_value("cl_io_req_ready", 128'(cl_io_req_ready),
                        128'(io_req_ready ? expect_grant(rr_last, cl_io_req_valid) : 4'd0));
            for (int i = 0; i < NCL; i++) begin
                if (cl_io_req_valid[i] && cl_io_req_ready[i]) begin
                    exp_q[i].push_back(expect_io_req(2'(i), cl_io_req[i]));
                    rr_last = 2'(i);
                end
            end
            if (hold_valid) begin
                check_value("io_req_valid", 128'(io_req_valid), 128'(1));
                check_value("io_req", 128'(io_req), 128'(held_req));
            end
            hold_valid = io_req_valid && !io_req_ready;
            held_req   = io_req;
            if (io_req_valid && io_req_ready) begin
                c = io_req.tag[5:4];
                if (exp_q[c].size() == 0) report_failure("io_req seen with no request pending");
                exp_req = exp_q[c].pop_front();
                check_value("io_req", 128'(io_req), 128'(exp_req));
            end
            if (io_rsp_valid) begin
                c = io_rsp.tag[5:4];
                check_value("cl_io_rsp_valid", 128'(cl_io_rsp_valid), 128'(4'b0001 << c));
                check_value("cl_io_rsp.data", 128'(cl_io_rsp[c].data), 128'(io_rsp.data));
                check_value("cl_io_rsp.tag", 128'(cl_io_rsp[c].tag), 128'(io_rsp.tag[3:0]));
                check_value("io_rsp_ready", 128'(io_rsp_ready), 128'(cl_io_rsp_ready[c]));
            end else begin
                check_value("cl_io_rsp_valid", 128'(cl_io_rsp_valid), 128'(0));
            end
            if (|cl_csr_req_valid) begin
                check_value("cl_csr_req_valid", 128'(cl_csr_req_valid),
                            128'(4'b0001 << exp_csr_target));
                check_value("cl_csr_req", 128'(cl_csr_req), 128'(exp_csr_cluster_req));
            end
            // Response ready only toward the owning cluster
            if (|cl_csr_rsp_ready) begin
                check_value("cl_csr_rsp_ready", 128'(cl_csr_rsp_ready),
                            128'(4'b0001 << exp_csr_target));
            end
        end
        prev_reset = reset;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the requests did not complete in time");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    initial begin
        wait (io_done == IO_TOTAL && csr_done == CSR_TOTAL);
        @(negedge clk);
        for (int i = 0; i < NCL; i++) begin
            if (exp_q[i].size() != 0) report_failure("accepted I/O requests never reached io_req");
        end
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, clear of the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire
